/* ctrl_pkg.sv */
package ctrl_pkg;

    //////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////
    typedef logic [31:0] instr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [11:0] csr_sel_t;   // I-type immediate or CSR address

    typedef enum logic [6:0] {
        OP_ARITH_R = 7'b0110011,
        OP_ARITH_I = 7'b0010011,
        OP_BRANCH  = 7'b1100011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_AUIPC   = 7'b0010111,
        OP_LUI     = 7'b0110111,
        OP_SYSTEM  = 7'b1110011
    } opcode_t;

    // funct7 groups of the register forms
    localparam funct7_t FUNCT7_BASE   = 7'b0000000;
    localparam funct7_t FUNCT7_ALT    = 7'b0100000;  // sub, sra, xnor, orn, andn
    localparam funct7_t FUNCT7_SHADD  = 7'b0010000;
    localparam funct7_t FUNCT7_MINMAX = 7'b0000101;
    localparam funct7_t FUNCT7_ROT    = 7'b0110000;
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

    localparam csr_sel_t EBREAK_IMM = 12'h001;

    //////////////////////////////////////////////////
    // Compute unit modes
    //////////////////////////////////////////////////
    typedef enum logic [7:0] {
        CCU_SUB    = 8'h00, CCU_ADD    = 8'h01, CCU_AND    = 8'h02,
        CCU_OR     = 8'h03, CCU_XOR    = 8'h04,
        CCU_RMV    = 8'h05, CCU_LMV    = 8'h06, CCU_ARMV   = 8'h07,  // Shifts
        CCU_SLTS   = 8'h08, CCU_SLTUS  = 8'h09,
        CCU_ANDN   = 8'h10, CCU_MAX    = 8'h11, CCU_MAXU   = 8'h12,
        CCU_MIN    = 8'h13, CCU_MINU   = 8'h14, CCU_ORN    = 8'h15,
        CCU_SH1ADD = 8'h16, CCU_SH2ADD = 8'h17, CCU_SH3ADD = 8'h18,
        CCU_XNOR   = 8'h19,
        CCU_CLZ    = 8'h34, CCU_CPOP   = 8'h35, CCU_CTZ    = 8'h36,  // Bit unit
        CCU_ROL    = 8'h37, CCU_ROR    = 8'h38, CCU_RORI   = 8'h3A,
        CCU_MUL    = 8'h40, CCU_MULH   = 8'h41, CCU_MULHSU = 8'h42,  // M unit
        CCU_MULHU  = 8'h43, CCU_DIV    = 8'h44, CCU_DIVU   = 8'h45,
        CCU_REM    = 8'h46, CCU_REMU   = 8'h47
    } ccu_mode_t;

    typedef enum logic [3:0] {
        JMP_NPC  = 4'h0, JMP_OFFPC = 4'h1,
        JMP_NEQ  = 4'h2, JMP_EQ    = 4'h3,
        JMP_SLT  = 4'h4, JMP_ULT   = 4'h5,
        JMP_SGT  = 4'h6, JMP_UGT   = 4'h7,
        JMP_JALR = 4'h8
    } jump_ctrl_t;

    typedef enum logic [2:0] {
        DMU_WORD   = 3'h0,
        DMU_HALF   = 3'h1,
        DMU_HALF_U = 3'h2,
        DMU_BYTE   = 3'h3,
        DMU_BYTE_U = 3'h4
    } dmu_mode_t;

    typedef enum logic [2:0] {SR1_REG = 3'h0, SR1_PC = 3'h1, SR1_CSR = 3'h2,
                              SR1_ZERO = 3'h3} sr1_sel_t;
    typedef enum logic [2:0] {SR2_REG = 3'h0, SR2_IMM = 3'h1, SR2_CSR = 3'h2,
                              SR2_ZERO = 3'h3} sr2_sel_t;
    typedef enum logic [2:0] {RF_CCU = 3'h0, RF_PCP4 = 3'h1, RF_DMU = 3'h2,
                              RF_CSR = 3'h3, RF_ZERO = 3'h6} rf_wb_sel_t;

    //////////////////////////////////////////////////
    // Control bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        sr1_sel_t   sr1_sel;
        sr2_sel_t   sr2_sel;
        rf_wb_sel_t rf_wb_sel;
        logic       ccu_ans_sel;   // Picks the M unit result
        ccu_mode_t  ccu_mode;
        logic       rfi_we;
        dmu_mode_t  dmu_mode;
        logic       dm_we;
        logic       dm_rd;
        logic       csr_we;
        jump_ctrl_t jump_ctrl;
        logic       ebreak;
    } ctrl_t;

    typedef struct packed {
        ccu_mode_t ccu_mode;
        logic      ccu_ans_sel;
    } mode_t;

    // Starting point of every decode
    localparam ctrl_t CTRL_DEFAULT = '{
        sr1_sel:     SR1_ZERO,
        sr2_sel:     SR2_ZERO,
        rf_wb_sel:   RF_ZERO,
        ccu_ans_sel: 1'b0,
        ccu_mode:    CCU_ADD,
        rfi_we:      1'b0,
        dmu_mode:    DMU_WORD,
        dm_we:       1'b0,
        dm_rd:       1'b0,
        csr_we:      1'b0,
        jump_ctrl:   JMP_NPC,
        ebreak:      1'b0
    };

endpackage

/* alu_mode_decoder.sv */
`timescale 1ns/1ps

module alu_mode_decoder (
    input  ctrl_pkg::instr_t instr,
    input  logic             is_imm,   // Immediate form, set by the opcode
    output ctrl_pkg::mode_t  mode
);
    import ctrl_pkg::*;

    funct3_t funct3;
    funct7_t funct7;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        mode.ccu_mode    = CCU_ADD;
        mode.ccu_ans_sel = 1'b0;

        if (is_imm) begin
            //////////////////////////////////////////////////
            // Immediate forms
            //////////////////////////////////////////////////
            case (funct3)
                3'b000: mode.ccu_mode = CCU_ADD;
                3'b010: mode.ccu_mode = CCU_SLTS;
                3'b011: mode.ccu_mode = CCU_SLTUS;
                3'b100: mode.ccu_mode = CCU_XOR;
                3'b110: mode.ccu_mode = CCU_OR;
                3'b111: mode.ccu_mode = CCU_AND;
                3'b001: begin
                    if (funct7 == FUNCT7_BASE) begin
                        mode.ccu_mode = CCU_LMV;   // slli
                    end else if (funct7 == FUNCT7_ROT) begin
                        case (instr[24:20])   // Count ops keyed by rs2
                            5'b00000: mode.ccu_mode = CCU_CLZ;
                            5'b00001: mode.ccu_mode = CCU_CTZ;
                            5'b00010: mode.ccu_mode = CCU_CPOP;
                            default:  mode.ccu_mode = CCU_ADD;
                        endcase
                    end
                end
                3'b101: begin
                    case (funct7)
                        FUNCT7_BASE, FUNCT7_ALT: begin
                            mode.ccu_mode = instr[30] ? CCU_ARMV : CCU_RMV;   // srai / srli
                        end
                        FUNCT7_ROT: mode.ccu_mode = CCU_RORI;
                        default:    mode.ccu_mode = CCU_ADD;
                    endcase
                end
                default: mode.ccu_mode = CCU_ADD;
            endcase
        end else begin
            //////////////////////////////////////////////////
            // Register forms
            //////////////////////////////////////////////////
            case (funct7)
                FUNCT7_BASE: begin
                    case (funct3)
                        3'b000: mode.ccu_mode = CCU_ADD;
                        3'b001: mode.ccu_mode = CCU_LMV;
                        3'b010: mode.ccu_mode = CCU_SLTS;
                        3'b011: mode.ccu_mode = CCU_SLTUS;
                        3'b100: mode.ccu_mode = CCU_XOR;
                        3'b101: mode.ccu_mode = CCU_RMV;
                        3'b110: mode.ccu_mode = CCU_OR;
                        3'b111: mode.ccu_mode = CCU_AND;
                    endcase
                end
                FUNCT7_ALT: begin
                    case (funct3)
                        3'b000:  mode.ccu_mode = CCU_SUB;
                        3'b100:  mode.ccu_mode = CCU_XNOR;
                        3'b101:  mode.ccu_mode = CCU_ARMV;
                        3'b110:  mode.ccu_mode = CCU_ORN;
                        3'b111:  mode.ccu_mode = CCU_ANDN;
                        default: mode.ccu_mode = CCU_ADD;
                    endcase
                end
                FUNCT7_SHADD: begin
                    case (funct3)
                        3'b010:  mode.ccu_mode = CCU_SH1ADD;
                        3'b100:  mode.ccu_mode = CCU_SH2ADD;
                        3'b110:  mode.ccu_mode = CCU_SH3ADD;
                        default: mode.ccu_mode = CCU_ADD;
                    endcase
                end
                FUNCT7_MINMAX: begin
                    case (funct3)
                        3'b100:  mode.ccu_mode = CCU_MIN;
                        3'b101:  mode.ccu_mode = CCU_MINU;
                        3'b110:  mode.ccu_mode = CCU_MAX;
                        3'b111:  mode.ccu_mode = CCU_MAXU;
                        default: mode.ccu_mode = CCU_ADD;
                    endcase
                end
                FUNCT7_ROT: begin
                    case (funct3)
                        3'b001:  mode.ccu_mode = CCU_ROL;
                        3'b101:  mode.ccu_mode = CCU_ROR;
                        default: mode.ccu_mode = CCU_ADD;
                    endcase
                end
                FUNCT7_MULDIV: begin
                    mode.ccu_ans_sel = 1'b1;   // Result from the M unit
                    case (funct3)
                        3'b000: mode.ccu_mode = CCU_MUL;
                        3'b001: mode.ccu_mode = CCU_MULH;
                        3'b010: mode.ccu_mode = CCU_MULHSU;
                        3'b011: mode.ccu_mode = CCU_MULHU;
                        3'b100: mode.ccu_mode = CCU_DIV;
                        3'b101: mode.ccu_mode = CCU_DIVU;
                        3'b110: mode.ccu_mode = CCU_REM;
                        3'b111: mode.ccu_mode = CCU_REMU;
                    endcase
                end
                default: mode.ccu_mode = CCU_ADD;
            endcase
        end

        // Answer mux must never pick the M unit for another mode
        assert (!mode.ccu_ans_sel || mode.ccu_mode inside {[CCU_MUL:CCU_REMU]})
            else $error("ccu_ans_sel set for mode %h", mode.ccu_mode);
    end

endmodule

/* csr_decoder.sv */
`timescale 1ns/1ps

module csr_decoder (
    input  ctrl_pkg::instr_t instr,
    output ctrl_pkg::ctrl_t  csr_ctrl
);
    import ctrl_pkg::*;

    funct3_t  funct3;
    csr_sel_t csr_sel;

    assign funct3  = instr[14:12];
    assign csr_sel = instr[31:20];

    always_comb begin
        csr_ctrl        = CTRL_DEFAULT;
        csr_ctrl.csr_we = 1'b1;

        if (csr_sel == EBREAK_IMM && instr[19:7] == '0) begin
            csr_ctrl.ebreak = 1'b1;   // Sources left at ZERO
        end else begin
            case (funct3)
                3'b001: begin   // csrrw
                    csr_ctrl.sr1_sel = SR1_REG;
                    csr_ctrl.sr2_sel = SR2_ZERO;
                end
                3'b010: begin   // csrrs
                    csr_ctrl.sr1_sel  = SR1_REG;
                    csr_ctrl.sr2_sel  = SR2_CSR;
                    csr_ctrl.ccu_mode = CCU_OR;
                end
                3'b011: begin   // csrrc
                    csr_ctrl.sr1_sel  = SR1_REG;
                    csr_ctrl.sr2_sel  = SR2_CSR;
                    csr_ctrl.ccu_mode = CCU_AND;
                end
                3'b101: begin   // csrrwi
                    csr_ctrl.sr1_sel = SR1_ZERO;
                    csr_ctrl.sr2_sel = SR2_IMM;
                end
                3'b110: begin   // csrrsi
                    csr_ctrl.sr1_sel  = SR1_CSR;
                    csr_ctrl.sr2_sel  = SR2_IMM;
                    csr_ctrl.ccu_mode = CCU_OR;
                end
                3'b111: begin   // csrrci
                    csr_ctrl.sr1_sel  = SR1_CSR;
                    csr_ctrl.sr2_sel  = SR2_IMM;
                    csr_ctrl.ccu_mode = CCU_AND;
                end
                default: csr_ctrl.ccu_mode = CCU_ADD;
            endcase
        end

        assert (!csr_ctrl.ebreak ||
                (csr_ctrl.sr1_sel == SR1_ZERO && csr_ctrl.sr2_sel == SR2_ZERO))
            else $error("ebreak with live operand sources");
    end

endmodule

/* main_decoder.sv */
`timescale 1ns/1ps

module main_decoder (
    input  ctrl_pkg::instr_t instr,
    output ctrl_pkg::ctrl_t  ctrl,
    output logic             error
);
    import ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    logic    is_imm;
    mode_t   alu_mode;
    ctrl_t   csr_ctrl;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign is_imm = (opcode == OP_ARITH_I);

    alu_mode_decoder u_alu_mode (
        .instr  (instr),
        .is_imm (is_imm),
        .mode   (alu_mode)
    );

    csr_decoder u_csr (
        .instr    (instr),
        .csr_ctrl (csr_ctrl)
    );

    //////////////////////////////////////////////////
    // Opcode dispatch
    //////////////////////////////////////////////////
    always_comb begin
        ctrl  = CTRL_DEFAULT;
        error = 1'b0;

        case (opcode)
            OP_ARITH_R, OP_ARITH_I: begin
                ctrl.sr1_sel     = SR1_REG;
                ctrl.sr2_sel     = is_imm ? SR2_IMM : SR2_REG;
                ctrl.rf_wb_sel   = RF_CCU;
                ctrl.rfi_we      = 1'b1;
                ctrl.ccu_mode    = alu_mode.ccu_mode;
                ctrl.ccu_ans_sel = alu_mode.ccu_ans_sel;
            end
            OP_BRANCH: begin
                ctrl.sr1_sel  = SR1_REG;
                ctrl.sr2_sel  = SR2_REG;
                ctrl.ccu_mode = CCU_SUB;   // Compare by subtraction
                case (funct3)
                    3'b001:  ctrl.jump_ctrl = JMP_NEQ;
                    3'b100:  ctrl.jump_ctrl = JMP_SLT;
                    3'b101:  ctrl.jump_ctrl = JMP_SGT;   // bge
                    3'b110:  ctrl.jump_ctrl = JMP_ULT;
                    3'b111:  ctrl.jump_ctrl = JMP_UGT;   // bgeu
                    default: ctrl.jump_ctrl = JMP_EQ;
                endcase
            end
            OP_LOAD: begin
                ctrl.sr1_sel   = SR1_REG;
                ctrl.sr2_sel   = SR2_IMM;
                ctrl.rf_wb_sel = RF_DMU;
                ctrl.rfi_we    = 1'b1;
                ctrl.dm_rd     = 1'b1;
                case (funct3)
                    3'b000:  ctrl.dmu_mode = DMU_BYTE;
                    3'b001:  ctrl.dmu_mode = DMU_HALF;
                    3'b100:  ctrl.dmu_mode = DMU_BYTE_U;
                    3'b101:  ctrl.dmu_mode = DMU_HALF_U;
                    default: ctrl.dmu_mode = DMU_WORD;
                endcase
            end
            OP_STORE: begin
                ctrl.sr1_sel = SR1_REG;
                ctrl.sr2_sel = SR2_IMM;
                ctrl.dm_we   = 1'b1;
            end
            OP_JAL: begin
                ctrl.rf_wb_sel = RF_PCP4;   // Link address
                ctrl.rfi_we    = 1'b1;
                ctrl.jump_ctrl = JMP_OFFPC;
            end
            OP_JALR: begin
                ctrl.sr1_sel   = SR1_REG;
                ctrl.sr2_sel   = SR2_IMM;
                ctrl.rf_wb_sel = RF_PCP4;
                ctrl.rfi_we    = 1'b1;
                ctrl.jump_ctrl = JMP_JALR;
            end
            OP_AUIPC, OP_LUI: begin
                ctrl.sr1_sel   = (opcode == OP_AUIPC) ? SR1_PC : SR1_ZERO;
                ctrl.sr2_sel   = SR2_IMM;
                ctrl.rf_wb_sel = RF_CCU;
                ctrl.rfi_we    = 1'b1;
            end
            OP_SYSTEM: begin
                ctrl.sr1_sel   = csr_ctrl.sr1_sel;
                ctrl.sr2_sel   = csr_ctrl.sr2_sel;
                ctrl.ccu_mode  = csr_ctrl.ccu_mode;
                ctrl.csr_we    = csr_ctrl.csr_we;
                ctrl.ebreak    = csr_ctrl.ebreak;
                ctrl.rf_wb_sel = RF_CSR;   // Old CSR value to rd
                ctrl.rfi_we    = 1'b1;
            end
            default: error = 1'b1;
        endcase

        // Rejected instruction must not touch any state
        assert (!error || !(ctrl.rfi_we || ctrl.dm_we || ctrl.dm_rd || ctrl.csr_we))
            else $error("error raised with a write or read enable set");
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic             clk,
    input  logic             reset,
    input  ctrl_pkg::instr_t instr,
    input  logic             instr_valid,
    output ctrl_pkg::ctrl_t  ctrl,
    output logic             ctrl_valid,
    output logic             error
);
    import ctrl_pkg::*;

    ctrl_t dec_ctrl;
    logic  dec_error;

    main_decoder u_main_decoder (
        .instr (instr),
        .ctrl  (dec_ctrl),
        .error (dec_error)
    );

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl       <= CTRL_DEFAULT;
            error      <= 1'b0;
            ctrl_valid <= 1'b0;
        end else begin
            ctrl_valid <= instr_valid;
            if (instr_valid) begin   // Hold last bundle while idle
                ctrl  <= dec_ctrl;
                error <= dec_error;
            end
        end
    end

    // One cycle from a sampled instruction to its valid output
    assert property (@(posedge clk) disable iff (reset)
                     !$past(reset) |-> ctrl_valid == $past(instr_valid))
        else $error("ctrl_valid does not follow instr_valid");

endmodule

/* tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_VECS = 37;

// Row fields: instr, sr1, sr2, writeback, ccu_mode, dmu_mode, jump, flags
// Flags: {ccu_ans_sel, rfi_we, dm_we, dm_rd, csr_we, ebreak, error}
task automatic load_vectors();
    // add sub sra xnor sh2add minu ror mul remu
    add_vec(32'h00B50533, SR1_REG, SR2_REG, RF_CCU, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h40B50533, SR1_REG, SR2_REG, RF_CCU, CCU_SUB, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h40B55533, SR1_REG, SR2_REG, RF_CCU, CCU_ARMV, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h40B54533, SR1_REG, SR2_REG, RF_CCU, CCU_XNOR, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h20B54533, SR1_REG, SR2_REG, RF_CCU, CCU_SH2ADD, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h0AB55533, SR1_REG, SR2_REG, RF_CCU, CCU_MINU, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h60B55533, SR1_REG, SR2_REG, RF_CCU, CCU_ROR, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h02B50533, SR1_REG, SR2_REG, RF_CCU, CCU_MUL, DMU_WORD, JMP_NPC, 7'b1100000);
    add_vec(32'h02B57533, SR1_REG, SR2_REG, RF_CCU, CCU_REMU, DMU_WORD, JMP_NPC, 7'b1100000);
    // addi srli srai rori clz ctz cpop, then funct7 0x7F on the shift-right slot
    add_vec(32'h00550513, SR1_REG, SR2_IMM, RF_CCU, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h00355513, SR1_REG, SR2_IMM, RF_CCU, CCU_RMV, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h40355513, SR1_REG, SR2_IMM, RF_CCU, CCU_ARMV, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h60355513, SR1_REG, SR2_IMM, RF_CCU, CCU_RORI, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h60051513, SR1_REG, SR2_IMM, RF_CCU, CCU_CLZ, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h60151513, SR1_REG, SR2_IMM, RF_CCU, CCU_CTZ, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h60251513, SR1_REG, SR2_IMM, RF_CCU, CCU_CPOP, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'hFE355513, SR1_REG, SR2_IMM, RF_CCU, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0100000);
    // lb lhu lw sw
    add_vec(32'h00450503, SR1_REG, SR2_IMM, RF_DMU, CCU_ADD, DMU_BYTE, JMP_NPC, 7'b0101000);
    add_vec(32'h00455503, SR1_REG, SR2_IMM, RF_DMU, CCU_ADD, DMU_HALF_U, JMP_NPC, 7'b0101000);
    add_vec(32'h00452503, SR1_REG, SR2_IMM, RF_DMU, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0101000);
    add_vec(32'h00B52423, SR1_REG, SR2_IMM, RF_ZERO, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0010000);
    // beq bge bltu jal jalr auipc lui
    add_vec(32'h00B50463, SR1_REG, SR2_REG, RF_ZERO, CCU_SUB, DMU_WORD, JMP_EQ, 7'b0000000);
    add_vec(32'h00B55463, SR1_REG, SR2_REG, RF_ZERO, CCU_SUB, DMU_WORD, JMP_SGT, 7'b0000000);
    add_vec(32'h00B56463, SR1_REG, SR2_REG, RF_ZERO, CCU_SUB, DMU_WORD, JMP_ULT, 7'b0000000);
    add_vec(32'h010000EF, SR1_ZERO, SR2_ZERO, RF_PCP4, CCU_ADD, DMU_WORD, JMP_OFFPC, 7'b0100000);
    add_vec(32'h000500E7, SR1_REG, SR2_IMM, RF_PCP4, CCU_ADD, DMU_WORD, JMP_JALR, 7'b0100000);
    add_vec(32'h12345517, SR1_PC, SR2_IMM, RF_CCU, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0100000);
    add_vec(32'h12345537, SR1_ZERO, SR2_IMM, RF_CCU, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0100000);
    // csrrw csrrs csrrc csrrwi csrrsi csrrci on mstatus, then ebreak
    add_vec(32'h30051573, SR1_REG, SR2_ZERO, RF_CSR, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0100100);
    add_vec(32'h30052573, SR1_REG, SR2_CSR, RF_CSR, CCU_OR, DMU_WORD, JMP_NPC, 7'b0100100);
    add_vec(32'h30053573, SR1_REG, SR2_CSR, RF_CSR, CCU_AND, DMU_WORD, JMP_NPC, 7'b0100100);
    add_vec(32'h30055573, SR1_ZERO, SR2_IMM, RF_CSR, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0100100);
    add_vec(32'h30056573, SR1_CSR, SR2_IMM, RF_CSR, CCU_OR, DMU_WORD, JMP_NPC, 7'b0100100);
    add_vec(32'h30057573, SR1_CSR, SR2_IMM, RF_CSR, CCU_AND, DMU_WORD, JMP_NPC, 7'b0100100);
    add_vec(32'h00100073, SR1_ZERO, SR2_ZERO, RF_CSR, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0100110);
    // flw and the all-zero word
    add_vec(32'h00452507, SR1_ZERO, SR2_ZERO, RF_ZERO, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0000001);
    add_vec(32'h00000000, SR1_ZERO, SR2_ZERO, RF_ZERO, CCU_ADD, DMU_WORD, JMP_NPC, 7'b0000001);
endtask

`endif

/* tb_decode_stage.sv */
`timescale 1ns/1ps

module tb_decode_stage;
    import ctrl_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;

    typedef struct packed {
        instr_t instr;
        ctrl_t  ctrl;
        logic   error;
    } vec_t;

    logic   clk;
    logic   reset;
    instr_t instr;
    logic   instr_valid;
    ctrl_t  ctrl;
    logic   ctrl_valid;
    logic   error;

    vec_t   vectors[$];
    integer seed = 92;
    int     pass_count   = 0;
    int     fail_count   = 0;
    int     other_errors = 0;   // Reset, idle and table checks
    int     last_row     = -1;  // Row whose bundle the outputs hold

    decode_stage UUT (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .ctrl_valid  (ctrl_valid),
        .error       (error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Builds one table row and appends it
    function automatic void add_vec(instr_t i, sr1_sel_t s1, sr2_sel_t s2, rf_wb_sel_t wb,
                                    ccu_mode_t m, dmu_mode_t d, jump_ctrl_t j,
                                    logic [6:0] f);
        vec_t v;
        v.instr            = i;
        v.ctrl.sr1_sel     = s1;
        v.ctrl.sr2_sel     = s2;
        v.ctrl.rf_wb_sel   = wb;
        v.ctrl.ccu_ans_sel = f[6];
        v.ctrl.ccu_mode    = m;
        v.ctrl.rfi_we      = f[5];
        v.ctrl.dmu_mode    = d;
        v.ctrl.dm_we       = f[4];
        v.ctrl.dm_rd       = f[3];
        v.ctrl.csr_we      = f[2];
        v.ctrl.jump_ctrl   = j;
        v.ctrl.ebreak      = f[1];
        v.error            = f[0];
        vectors.push_back(v);
    endfunction

    `include "tb_vectors.svh"

    //////////////////////////////////////////////////
    // Output checks, one slot per clock
    //////////////////////////////////////////////////
    task automatic check_slot(input int idx);
        vec_t v;
        bit   ok;
        begin
            ok = 1'b1;
            if (idx < 0) begin   // Idle slot
                assert (ctrl_valid === 1'b0) else begin
                    $display("Time %0t: ctrl_valid high after an idle cycle", $time);
                    other_errors++;
                end
                if (last_row >= 0) begin   // Bundle of the last decode stays
                    v = vectors[last_row];
                    assert (ctrl === v.ctrl) else begin
                        $display("MISMATCH time %0t ctrl: expected %h, actual %h while idle",
                                 $time, v.ctrl, ctrl);
                        other_errors++;
                    end
                    assert (error === v.error) else begin
                        $display("MISMATCH time %0t error: expected %b, actual %b while idle",
                                 $time, v.error, error);
                        other_errors++;
                    end
                end
            end else begin
                v = vectors[idx];
                last_row = idx;
                assert (ctrl_valid === 1'b1) else begin
                    $display("Time %0t: ctrl_valid low one cycle after instr %h",
                             $time, v.instr);
                    ok = 1'b0;
                end
                assert (ctrl === v.ctrl) else begin
                    $display("MISMATCH time %0t ctrl: expected %h, actual %h",
                             $time, v.ctrl, ctrl);
                    ok = 1'b0;
                end
                assert (error === v.error) else begin
                    $display("MISMATCH time %0t error: expected %b, actual %b",
                             $time, v.error, error);
                    ok = 1'b0;
                end
                if (ok) begin
                    pass_count++;
                    $display("Test %0d instr %h: ok", idx, v.instr);
                end else begin
                    fail_count++;
                    $display("Test %0d instr %h: failed", idx, v.instr);
                end
            end
        end
    endtask

    initial begin
        int slots[$];   // Row index per cycle, -1 for idle
        int gap;
        clk         = 1'b0;
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        load_vectors();
        assert (vectors.size() == NUM_VECS) else begin
            $display("Table holds %0d rows instead of %0d", vectors.size(), NUM_VECS);
            other_errors++;
        end

        for (int i = 0; i < vectors.size(); i++) begin
            gap = {$random(seed)} % 3;   // Zero to two idle cycles
            repeat (gap) slots.push_back(-1);
            slots.push_back(i);
        end

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1) reset <= 1'b0;
            @(negedge clk);
            assert (ctrl_valid === 1'b0 && error === 1'b0) else begin
                $display("Time %0t: ctrl_valid or error high during reset", $time);
                other_errors++;
            end
            assert (!(ctrl.rfi_we || ctrl.dm_we || ctrl.dm_rd || ctrl.csr_we || ctrl.ebreak))
                else begin
                    $display("Time %0t: enable or ebreak set in reset bundle", $time);
                    other_errors++;
                end
        end

        // Slot s drives at its edge; outputs of slot s-1 are seen at the next negedge
        for (int s = 0; s <= slots.size(); s++) begin
            @(posedge clk);
            if (s < slots.size() && slots[s] >= 0) begin
                instr       <= vectors[slots[s]].instr;
                instr_valid <= 1'b1;
            end else begin
                instr_valid <= 1'b0;
            end
            @(negedge clk);
            check_slot((s == 0) ? -1 : slots[s - 1]);
        end

        $display("Summary: %0d tests passed, %0d failed, %0d other errors",
                 pass_count, fail_count, other_errors);
        if (fail_count == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (NUM_VECS * 4 + 20));
        $display("Watchdog expired before the table finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
ctrl_pkg.sv
alu_mode_decoder.sv
csr_decoder.sv
main_decoder.sv
decode_stage.sv
tb_decode_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -j 0
TOP       = tb_decode_stage
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
